// ==== src/icachePkg.sv ====
/* Geometry and state encoding for the two-way instruction cache.
   Address split is tag 31:8, index 7:4, word offset 3:2; bits 1:0 are ignored. */

package icachePkg;

  // Address and data widths
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // Line geometry
  localparam int wordsPerLine = 4;
  localparam int offsetBits = 2;

  // Set geometry
  localparam int numSets = 16;
  localparam int indexBits = 4;
  localparam int tagBits = addrWidth - indexBits - offsetBits - 2;

  // Controller states
  typedef enum logic [1:0] {
    ctlReady,
    ctlRefill,
    ctlReplay
  } ctlState;

endpackage

// ==== src/icacheTagArray.sv ====
/* Tags, valid bits and one LRU bit per set for both ways. Reads are combinational.
   Victim is the first invalid way, else the least recently used one. */

`timescale 1ns/10ps

module icacheTagArray import icachePkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic [indexBits-1:0] index,
  input  logic [tagBits-1:0]   tag,
  input  logic [indexBits-1:0] fillIndex,
  input  logic [tagBits-1:0]   fillTag,
  input  logic                 fillWay,
  input  logic                 fillWe,
  input  logic                 touchWe,
  input  logic                 touchWay,
  output logic                 hit,
  output logic                 hitWay,
  output logic                 victimWay
);

  logic [tagBits-1:0] tags [2][numSets];
  logic [numSets-1:0] valid [2];
  // Holds the way to evict next
  logic [numSets-1:0] lru;
  logic hit0, hit1;

  assign hit0 = valid[0][index] && (tags[0][index] == tag);
  assign hit1 = valid[1][index] && (tags[1][index] == tag);
  assign hit = hit0 | hit1;
  assign hitWay = hit1;

  always_comb begin
    if (!valid[0][index]) victimWay = 1'b0;
    else if (!valid[1][index]) victimWay = 1'b1;
    else victimWay = lru[index];
  end

  // Tag storage
  always_ff @(posedge clk) begin
    if (fillWe) tags[fillWay][fillIndex] <= fillTag;
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid[0] <= '0;
      valid[1] <= '0;
      lru <= '0;
    end else begin
      // Used way becomes most recent, so the other one is next to go
      if (fillWe) begin
        valid[fillWay][fillIndex] <= 1'b1;
        lru[fillIndex] <= ~fillWay;
      end
      if (touchWe) lru[index] <= ~touchWay;
    end
  end

  aNoDoubleHit: assert property (@(posedge clk) disable iff (reset) !(hit0 && hit1));

endmodule

// ==== src/icacheDataArray.sv ====
/* Line storage for both ways, 16 sets of 4 words each. No reset on contents.
   Read is combinational, one refill word is written per edge. */

`timescale 1ns/10ps

module icacheDataArray import icachePkg::*; (
  input  logic                  clk,
  input  logic [indexBits-1:0]  index,
  input  logic                  way,
  input  logic [offsetBits-1:0] offset,
  input  logic [indexBits-1:0]  wrIndex,
  input  logic                  wrWay,
  input  logic [offsetBits-1:0] wrOffset,
  input  logic [dataWidth-1:0]  wrData,
  input  logic                  we,
  output logic [dataWidth-1:0]  rdData
);

  logic [dataWidth-1:0] mem [2][numSets][wordsPerLine];

  // Compare stage word select
  assign rdData = mem[way][index][offset];

  always_ff @(posedge clk) begin
    if (we) mem[wrWay][wrIndex][wrOffset] <= wrData;
  end

endmodule

// ==== src/icacheLineFetch.sv ====
/* Wishbone classic read master for one cache line, always starting at word 0.
   Strobe stays high across all four transfers; start must not come while busy. */

`timescale 1ns/10ps

module icacheLineFetch import icachePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [addrWidth-1:0]  lineAddr,
  input  logic [dataWidth-1:0]  wbDatIn,
  input  logic                  wbAck,
  output logic                  wbCyc,
  output logic                  wbStb,
  output logic [addrWidth-1:0]  wbAdr,
  output logic                  wordValid,
  output logic [offsetBits-1:0] wordOffset,
  output logic [dataWidth-1:0]  wordData,
  output logic                  done
);

  logic busy;
  logic [offsetBits-1:0] count;
  logic [addrWidth-1:offsetBits+2] lineBase;

  assign wbCyc = busy;
  assign wbStb = busy;
  assign wbAdr = {lineBase, count, 2'b00};

  // Forward each acked word straight through
  assign wordValid = busy & wbAck;
  assign wordOffset = count;
  assign wordData = wbDatIn;
  assign done = wordValid && (count == offsetBits'(wordsPerLine - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      count <= '0;
    end else if (wordValid) begin
      count <= count + 1'b1;
      if (done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) lineBase <= lineAddr[addrWidth-1:offsetBits+2];
  end

  // Address must not move while a transfer waits for its ack
  aAdrHeld: assert property (@(posedge clk) disable iff (reset)
    wbStb && !wbAck |=> $stable(wbAdr));
  aStartIdle: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

// ==== src/icacheController.sv ====
/* Lookup and compare pipeline plus the miss/refill/replay FSM.
   A fetch accepted in the miss cycle waits in lookup until the replay is done. */

`timescale 1ns/10ps

module icacheController import icachePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetchValid,
  input  logic [addrWidth-1:0]  fetchAddr,
  input  logic                  flush,
  input  logic                  hit,
  input  logic                  hitWay,
  input  logic                  victimWay,
  input  logic [dataWidth-1:0]  rdData,
  input  logic                  wordValid,
  input  logic [offsetBits-1:0] wordOffset,
  input  logic [dataWidth-1:0]  wordData,
  input  logic                  done,
  output logic                  stall,
  output logic                  instrValid,
  output logic [dataWidth-1:0]  instr,
  output logic [indexBits-1:0]  lookupIndex,
  output logic [tagBits-1:0]    lookupTag,
  output logic [offsetBits-1:0] lookupOffset,
  output logic                  readWay,
  output logic                  touchWe,
  output logic                  fillWe,
  output logic                  fillWay,
  output logic                  dataWe,
  output logic                  start,
  output logic [addrWidth-1:0]  lineAddr
);

  ctlState state;
  logic lkValid;
  logic [addrWidth-1:0] lkAddr;
  logic [addrWidth-1:0] missAddr;
  logic [addrWidth-1:0] selAddr;
  logic missWay;
  logic [dataWidth-1:0] missWord;
  logic compareValid;
  logic missDetect;

  // Arrays see the held miss address outside ctlReady
  assign selAddr = (state == ctlReady) ? lkAddr : missAddr;
  assign lookupOffset = selAddr[offsetBits+1:2];
  assign lookupIndex = selAddr[indexBits+offsetBits+1:offsetBits+2];
  assign lookupTag = selAddr[addrWidth-1:addrWidth-tagBits];
  assign readWay = hitWay;

  assign compareValid = ((state == ctlReady) && lkValid) || (state == ctlReplay);
  assign missDetect = (state == ctlReady) && lkValid && !hit;
  assign stall = (state != ctlReady);

  // Flush resets LRU anyway
  assign touchWe = compareValid && hit && !flush;

  // Refill always starts at word 0
  assign start = missDetect;
  assign lineAddr = {lkAddr[addrWidth-1:offsetBits+2], {(offsetBits + 2){1'b0}}};
  assign dataWe = wordValid && (state == ctlRefill);
  assign fillWe = done && (state == ctlRefill);
  assign fillWay = missWay;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctlReady;
    end else begin
      case (state)
        ctlReady: if (missDetect) state <= ctlRefill;
        ctlRefill: if (done) state <= ctlReplay;
        ctlReplay: state <= ctlReady;
        default: state <= ctlReady;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lkValid <= 1'b0;
      instrValid <= 1'b0;
    end else begin
      if (!stall) lkValid <= fetchValid;
      instrValid <= compareValid && hit;
    end
  end

  always_ff @(posedge clk) begin
    if (fetchValid && !stall) lkAddr <= fetchAddr;
    if (missDetect) begin
      missAddr <= lkAddr;
      missWay <= victimWay;
    end
    // Keep the requested word as it goes by
    if (dataWe && (wordOffset == missAddr[offsetBits+1:2])) missWord <= wordData;
    if (compareValid && hit) instr <= (state == ctlReplay) ? missWord : rdData;
  end

  aNoValidInRefill: assert property (@(posedge clk) disable iff (reset)
    instrValid |-> state != ctlRefill);

  // Filled line must be visible and match what came off the bus
  aReplayHits: assert property (@(posedge clk) disable iff (reset)
    state == ctlReplay |-> hit && (rdData == missWord));

endmodule

// ==== src/icacheTop.sv ====
/* Two-way read-only instruction cache with a Wishbone classic refill port.
   Flush is honored only on edges where stall is low. */

`timescale 1ns/10ps

module icacheTop import icachePkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetchValid,
  input  logic [addrWidth-1:0] fetchAddr,
  input  logic                 flush,
  output logic                 stall,
  output logic                 instrValid,
  output logic [dataWidth-1:0] instr,
  output logic                 wbCyc,
  output logic                 wbStb,
  output logic [addrWidth-1:0] wbAdr,
  input  logic [dataWidth-1:0] wbDatIn,
  input  logic                 wbAck
);

  logic hit, hitWay, victimWay;
  logic [dataWidth-1:0] rdData;
  logic wordValid, done;
  logic [offsetBits-1:0] wordOffset;
  logic [dataWidth-1:0] wordData;
  logic [indexBits-1:0] lookupIndex;
  logic [tagBits-1:0] lookupTag;
  logic [offsetBits-1:0] lookupOffset;
  logic readWay, touchWe, fillWe, fillWay, dataWe, start;
  logic [addrWidth-1:0] lineAddr;

  icacheController controller_i (
    .clk(clk), .reset(reset), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .flush(flush), .hit(hit), .hitWay(hitWay), .victimWay(victimWay), .rdData(rdData),
    .wordValid(wordValid), .wordOffset(wordOffset), .wordData(wordData), .done(done),
    .stall(stall), .instrValid(instrValid), .instr(instr), .lookupIndex(lookupIndex),
    .lookupTag(lookupTag), .lookupOffset(lookupOffset), .readWay(readWay),
    .touchWe(touchWe), .fillWe(fillWe), .fillWay(fillWay), .dataWe(dataWe),
    .start(start), .lineAddr(lineAddr)
  );

  // Fill writes use the held miss address on the lookup lines
  icacheTagArray tagArray_i (
    .clk(clk), .reset(reset), .flush(flush & ~stall), .index(lookupIndex),
    .tag(lookupTag), .fillIndex(lookupIndex), .fillTag(lookupTag), .fillWay(fillWay),
    .fillWe(fillWe), .touchWe(touchWe), .touchWay(hitWay), .hit(hit), .hitWay(hitWay),
    .victimWay(victimWay)
  );

  icacheDataArray dataArray_i (
    .clk(clk), .index(lookupIndex), .way(readWay), .offset(lookupOffset),
    .wrIndex(lookupIndex), .wrWay(fillWay), .wrOffset(wordOffset), .wrData(wordData),
    .we(dataWe), .rdData(rdData)
  );

  icacheLineFetch lineFetch_i (
    .clk(clk), .reset(reset), .start(start), .lineAddr(lineAddr), .wbDatIn(wbDatIn),
    .wbAck(wbAck), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wordValid(wordValid),
    .wordOffset(wordOffset), .wordData(wordData), .done(done)
  );

endmodule

// ==== dv/icacheChecker.sv ====
/* Matches returned instructions to accepted fetches in order and checks refill traffic.
   A fetch counts as a miss if a Wishbone cycle starts while it is the oldest outstanding. */

`timescale 1ns/10ps

module icacheChecker import icachePkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetchValid,
  input  logic [addrWidth-1:0] fetchAddr,
  input  logic [dataWidth-1:0] expInstr,
  input  logic                 expHit,
  input  logic                 stall,
  input  logic                 instrValid,
  input  logic [dataWidth-1:0] instr,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbAck,
  input  logic [addrWidth-1:0] wbAdr,
  output int                   errorCount,
  output int                   fetchCount
);

  logic [addrWidth-1:0] qAddr [$];
  logic [dataWidth-1:0] qInstr [$];
  logic qHit [$];
  logic qMiss [$];
  int qCycle [$];
  int qEpoch [$];
  int cycle = 0;
  int epoch = 0;
  int ackCount = 0;
  logic prevCyc = 1'b0;

  always @(posedge clk) begin
    logic [addrWidth-1:0] expAdr;
    logic gotHit;
    int lat;
    cycle++;
    if (reset) begin
      errorCount = 0;
      fetchCount = 0;
      prevCyc = 1'b0;
    end else begin
      // Strobe has no gaps within a line, so it tracks the cycle signal
      if (wbStb !== wbCyc) begin
        $display("FAIL t=%0t wbStb and wbCyc differ, wbCyc %0d wbStb %0d", $time,
          wbCyc, wbStb);
        errorCount++;
      end

      // Refill bookkeeping
      if (wbCyc && !prevCyc) begin
        epoch++;
        ackCount = 0;
        if (qMiss.size() == 0) begin
          $display("Wishbone cycle started with no fetch outstanding at %0t", $time);
          errorCount++;
        end else begin
          qMiss[0] = 1'b1;
        end
      end
      if (wbStb && wbAck && qAddr.size() > 0) begin
        expAdr = {qAddr[0][addrWidth-1:4], 2'(ackCount), 2'b00};
        if (wbAdr !== expAdr) begin
          $display("FAIL t=%0t addr=%h wbAdr expected %h got %h", $time, qAddr[0],
            expAdr, wbAdr);
          errorCount++;
        end
      end
      if (wbStb && wbAck) ackCount++;
      if (!wbCyc && prevCyc && ackCount != wordsPerLine) begin
        $display("FAIL t=%0t transfers per line expected %0d got %0d", $time,
          wordsPerLine, ackCount);
        errorCount++;
      end
      prevCyc = wbCyc;

      // Oldest fetch retires first
      if (instrValid) begin
        if (qAddr.size() == 0) begin
          $display("instrValid with no fetch outstanding at %0t", $time);
          errorCount++;
        end else begin
          gotHit = !qMiss[0];
          lat = cycle - qCycle[0];
          if (instr !== qInstr[0]) begin
            $display("FAIL t=%0t addr=%h instr expected %h got %h", $time, qAddr[0],
              qInstr[0], instr);
            errorCount++;
          end
          if (gotHit !== qHit[0]) begin
            $display("FAIL t=%0t addr=%h hit expected %0d got %0d", $time, qAddr[0],
              qHit[0], gotHit);
            errorCount++;
          end
          if (gotHit && qEpoch[0] == epoch && lat != 2) begin
            $display("FAIL t=%0t addr=%h hit latency expected 2 got %0d", $time,
              qAddr[0], lat);
            errorCount++;
          end
          void'(qAddr.pop_front());
          void'(qInstr.pop_front());
          void'(qHit.pop_front());
          void'(qMiss.pop_front());
          void'(qCycle.pop_front());
          void'(qEpoch.pop_front());
          fetchCount++;
        end
      end

      if (fetchValid && !stall) begin
        qAddr.push_back(fetchAddr);
        qInstr.push_back(expInstr);
        qHit.push_back(expHit);
        qMiss.push_back(1'b0);
        qCycle.push_back(cycle);
        qEpoch.push_back(epoch);
      end
    end
  end

endmodule

// ==== dv/icacheTb.sv ====
/* Testbench for the instruction cache. Fetches and flushes come from dv/icacheGolden.txt.
   Memory word at byte address A is A ^ 32'h5a5a_a5a5, acked after 0 to 3 cycles. */

`timescale 1ns/10ps

module icacheTb import icachePkg::*; ();

  logic clk;
  logic reset;
  logic fetchValid;
  logic [addrWidth-1:0] fetchAddr;
  logic flush;
  logic stall;
  logic instrValid;
  logic [dataWidth-1:0] instr;
  logic wbCyc;
  logic wbStb;
  logic [addrWidth-1:0] wbAdr;
  logic [dataWidth-1:0] wbDatIn;
  logic wbAck;
  logic [dataWidth-1:0] expInstr;
  logic expHit;
  int errorCount;
  int fetchCount;

  // Golden entries
  logic [31:0] gOp [$];
  logic [31:0] gAddr [$];
  logic [31:0] gInstr [$];
  logic [31:0] gHit [$];
  int issued = 0;
  int cycles = 0;
  int limit = 0;

  icacheTop icacheTop_i (
    .clk(clk), .reset(reset), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .flush(flush), .stall(stall), .instrValid(instrValid), .instr(instr),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDatIn(wbDatIn), .wbAck(wbAck)
  );

  icacheChecker checker_i (
    .clk(clk), .reset(reset), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .expInstr(expInstr), .expHit(expHit), .stall(stall), .instrValid(instrValid),
    .instr(instr), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck), .wbAdr(wbAdr),
    .errorCount(errorCount), .fetchCount(fetchCount)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Wishbone memory, one ack per strobe
  initial begin
    int delay;
    wbAck = 1'b0;
    wbDatIn = '0;
    void'($urandom(32'hf869_733a));
    forever begin
      @(negedge clk);
      wbAck = 1'b0;
      if (wbStb && !reset) begin
        delay = int'($urandom % 4);
        repeat (delay) @(negedge clk);
        wbDatIn = wbAdr ^ 32'h5a5a_a5a5;
        wbAck = 1'b1;
      end
    end
  end

  // Cycle limit
  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d fetches returned",
      cycles, fetchCount, issued);
    $display("Simulation failed");
    $finish;
  end

  task automatic driveFetch(input logic [31:0] addr, input logic [31:0] exp,
      input logic hitFlag);
    @(negedge clk);
    fetchValid = 1'b1;
    fetchAddr = addr;
    expInstr = exp;
    expHit = hitFlag;
    // Hold the fetch until an edge with stall low
    while (stall) @(negedge clk);
    issued++;
  endtask

  task automatic waitDrained();
    @(negedge clk);
    fetchValid = 1'b0;
    while (fetchCount != issued) @(negedge clk);
  endtask

  task automatic flushCache();
    waitDrained();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // Returns 0 when the file cannot be opened
  function automatic bit readGolden();
    int fd;
    int n;
    string line;
    logic [31:0] op, addr, ins, h;
    fd = $fopen("dv/icacheGolden.txt", "r");
    if (fd == 0) return 1'b0;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == 8'h23) continue;
      n = $sscanf(line, "%h %h %h %h", op, addr, ins, h);
      if (n == 4) begin
        gOp.push_back(op);
        gAddr.push_back(addr);
        gInstr.push_back(ins);
        gHit.push_back(h);
      end
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  initial begin
    reset = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    flush = 1'b0;
    expInstr = '0;
    expHit = 1'b0;
    if (!readGolden()) begin
      $display("Cannot open golden file dv/icacheGolden.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      limit = gOp.size() * 30 + 50;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      foreach (gOp[i]) begin
        if (gOp[i] == 32'd1) flushCache();
        else driveFetch(gAddr[i], gInstr[i], gHit[i][0]);
      end
      waitDrained();
      // A few idle cycles to catch stray outputs
      repeat (4) @(negedge clk);
      $display("Errors: %0d, fetches returned: %0d of %0d", errorCount, fetchCount, issued);
      if (errorCount == 0 && fetchCount == issued) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== dv/icacheGolden.txt ====
# op (0 fetch, 1 flush)  byte address  expected instruction  expected hit (1 hit, 0 miss)
# all fields hex; flush lines ignore the other columns
0 00001004 5a5ab5a1 0
0 00001000 5a5ab5a5 1
0 00001008 5a5ab5ad 1
0 0000100c 5a5ab5a9 1
0 00002000 5a5a85a5 0
0 00001004 5a5ab5a1 1
0 00003000 5a5a95a5 0
0 00001008 5a5ab5ad 1
0 00002004 5a5a85a1 0
0 00003004 5a5a95a1 0
0 0000200c 5a5a85a9 1
0 00000040 5a5aa5e5 0
0 00000044 5a5aa5e1 1
0 00000048 5a5aa5ed 1
0 00003008 5a5a95ad 1
1 00000000 00000000 0
0 0000004c 5a5aa5e9 0
0 00000040 5a5aa5e5 1
0 00003000 5a5a95a5 0
0 0000300c 5a5a95a9 1
0 0000fff0 5a5a5a55 0
0 0000fffc 5a5a5a59 1

// ==== all.f ====
src/icachePkg.sv
src/icacheTagArray.sv
src/icacheDataArray.sv
src/icacheLineFetch.sv
src/icacheController.sv
src/icacheTop.sv
dv/icacheChecker.sv
dv/icacheTb.sv

// ==== Makefile ====
TOP = icacheTb

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
